// File: verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam int ADDR_W = 32;
  localparam int INST_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [INST_W-1:0] inst_t;

  // axi read response code where zero is okay
  typedef logic [1:0] resp_t;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_ar_req,
    st_r_wait,
    st_deliver
  } fetch_state_t;

endpackage

`default_nettype wire

// File: verilog/perf_pkg.sv
`default_nettype none

package perf_pkg;

  localparam int CNT_W = 32;

  typedef logic [CNT_W-1:0] perf_cnt_t;

endpackage

`default_nettype wire

// File: verilog/icache.sv
`timescale 1ns/1ps
`default_nettype none

// direct-mapped with one 32-bit word per line
module icache
  import fetch_pkg::*;
#(
  parameter int CACHE_LINES = 16
) (
  input  logic  i_clock,
  input  logic  i_arst_n,
  input  addr_t i_lookup_addr,
  output logic  o_hit,
  output inst_t o_data,
  input  logic  i_fill_en,
  input  inst_t i_fill_data
);

  // CACHE_LINES must be a power of two of at least 2
  localparam int IDX_W = $clog2(CACHE_LINES);
  localparam int TAG_W = ADDR_W - IDX_W - 2;

  logic [IDX_W-1:0]       idx;
  logic [TAG_W-1:0]       tag;
  logic [CACHE_LINES-1:0] valid_q;
  logic [TAG_W-1:0]       tag_mem [CACHE_LINES];
  inst_t                  data_mem [CACHE_LINES];

  // byte offset bits [1:0] do not take part in the lookup
  assign idx = i_lookup_addr[IDX_W+1:2];
  assign tag = i_lookup_addr[ADDR_W-1:IDX_W+2];

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= '0;
    end else if (i_fill_en) begin
      valid_q[idx] <= 1'b1;
    end
  end

  // refill lands at the line of the current lookup address
  always_ff @(posedge i_clock) begin
    if (i_fill_en) begin
      tag_mem[idx]  <= tag;
      data_mem[idx] <= i_fill_data;
    end
  end

  assign o_hit  = valid_q[idx] && (tag_mem[idx] == tag);
  assign o_data = data_mem[idx];

endmodule

`default_nettype wire

// File: verilog/fetch_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_fsm
  import fetch_pkg::*;
(
  input  logic  i_clock,
  input  logic  i_arst_n,
  // write-back side
  input  logic  i_pc_update,
  input  addr_t i_pc_next,
  // icache
  input  logic  i_hit,
  input  inst_t i_cache_data,
  output addr_t o_lookup_addr,
  output logic  o_fill_en,
  output inst_t o_fill_data,
  // axi read master
  output logic  o_arvalid,
  output addr_t o_araddr,
  input  logic  i_arready,
  input  logic  i_rvalid,
  input  inst_t i_rdata,
  input  resp_t i_rresp,
  output logic  o_rready,
  // decode side
  output logic  o_inst_valid,
  output inst_t o_inst,
  output logic  o_inst_fault,
  output addr_t o_pc,
  input  logic  i_inst_ready,
  // perf events
  output logic  o_hit_evt,
  output logic  o_miss_evt,
  output logic  o_busy
);

  fetch_state_t state_q;
  fetch_state_t state_d;
  addr_t        pc_q;
  inst_t        inst_q;
  logic         fault_q;
  logic         r_beat;

  assign r_beat = (state_q == st_r_wait) && i_rvalid;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      st_idle: begin
        if (i_pc_update) begin
          state_d = st_lookup;
        end
      end
      st_lookup: begin
        state_d = i_hit ? st_deliver : st_ar_req;
      end
      st_ar_req: begin
        if (i_arready) begin
          state_d = st_r_wait;
        end
      end
      st_r_wait: begin
        if (i_rvalid) begin
          state_d = st_deliver;
        end
      end
      st_deliver: begin
        if (i_inst_ready) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge i_clock) begin
    if ((state_q == st_idle) && i_pc_update) begin
      pc_q <= i_pc_next;
    end
    if ((state_q == st_lookup) && i_hit) begin
      inst_q  <= i_cache_data;
      fault_q <= 1'b0;
    end
    // a bad response is still delivered, flagged as a fault
    if (r_beat) begin
      inst_q  <= i_rdata;
      fault_q <= (i_rresp != '0);
    end
  end

  assign o_lookup_addr = pc_q;
  // only okay data goes into the cache
  assign o_fill_en     = r_beat && (i_rresp == '0);
  assign o_fill_data   = i_rdata;

  assign o_arvalid = (state_q == st_ar_req);
  assign o_araddr  = pc_q;
  assign o_rready  = (state_q == st_r_wait);

  assign o_inst_valid = (state_q == st_deliver);
  assign o_inst       = inst_q;
  assign o_inst_fault = fault_q;
  assign o_pc         = pc_q;

  assign o_hit_evt  = (state_q == st_lookup) && i_hit;
  assign o_miss_evt = (state_q == st_lookup) && !i_hit;
  assign o_busy     = (state_q != st_idle);

endmodule

`default_nettype wire

// File: verilog/fetch_perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_perf_counters
  import perf_pkg::*;
(
  input  logic      i_clock,
  input  logic      i_arst_n,
  input  logic      i_hit_evt,
  input  logic      i_miss_evt,
  input  logic      i_busy,
  output perf_cnt_t o_hit_count,
  output perf_cnt_t o_miss_count,
  output perf_cnt_t o_busy_cycles
);

  localparam int N_CNT = 3;

  logic [N_CNT-1:0] evt;
  perf_cnt_t        cnt_q [N_CNT];

  // slot 0 hits, slot 1 misses, slot 2 busy cycles
  assign evt = {i_busy, i_miss_evt, i_hit_evt};

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < N_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_CNT; i++) begin
        // stick at all ones
        if (evt[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + perf_cnt_t'(1);
        end
      end
    end
  end

  assign o_hit_count   = cnt_q[0];
  assign o_miss_count  = cnt_q[1];
  assign o_busy_cycles = cnt_q[2];

endmodule

`default_nettype wire

// File: verilog/ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_top
  import fetch_pkg::*;
  import perf_pkg::*;
#(
  parameter int CACHE_LINES = 16
) (
  input  logic      i_clock,
  input  logic      i_arst_n,
  input  logic      i_pc_update,
  input  addr_t     i_pc_next,
  input  logic      i_inst_ready,
  output logic      o_inst_valid,
  output inst_t     o_inst,
  output logic      o_inst_fault,
  output addr_t     o_pc,
  output logic      o_arvalid,
  output addr_t     o_araddr,
  input  logic      i_arready,
  input  logic      i_rvalid,
  input  inst_t     i_rdata,
  input  resp_t     i_rresp,
  output logic      o_rready,
  output perf_cnt_t o_hit_count,
  output perf_cnt_t o_miss_count,
  output perf_cnt_t o_busy_cycles
);

  addr_t lookup_addr;
  logic  cache_hit;
  inst_t cache_data;
  logic  fill_en;
  inst_t fill_data;
  logic  hit_evt;
  logic  miss_evt;
  logic  busy;

  icache #(
    .CACHE_LINES(CACHE_LINES)
  ) icache_i (
    .i_clock      (i_clock),
    .i_arst_n     (i_arst_n),
    .i_lookup_addr(lookup_addr),
    .o_hit        (cache_hit),
    .o_data       (cache_data),
    .i_fill_en    (fill_en),
    .i_fill_data  (fill_data)
  );

  fetch_fsm fetch_fsm_i (
    .i_clock      (i_clock),
    .i_arst_n     (i_arst_n),
    .i_pc_update  (i_pc_update),
    .i_pc_next    (i_pc_next),
    .i_hit        (cache_hit),
    .i_cache_data (cache_data),
    .o_lookup_addr(lookup_addr),
    .o_fill_en    (fill_en),
    .o_fill_data  (fill_data),
    .o_arvalid    (o_arvalid),
    .o_araddr     (o_araddr),
    .i_arready    (i_arready),
    .i_rvalid     (i_rvalid),
    .i_rdata      (i_rdata),
    .i_rresp      (i_rresp),
    .o_rready     (o_rready),
    .o_inst_valid (o_inst_valid),
    .o_inst       (o_inst),
    .o_inst_fault (o_inst_fault),
    .o_pc         (o_pc),
    .i_inst_ready (i_inst_ready),
    .o_hit_evt    (hit_evt),
    .o_miss_evt   (miss_evt),
    .o_busy       (busy)
  );

  fetch_perf_counters perf_i (
    .i_clock      (i_clock),
    .i_arst_n     (i_arst_n),
    .i_hit_evt    (hit_evt),
    .i_miss_evt   (miss_evt),
    .i_busy       (busy),
    .o_hit_count  (o_hit_count),
    .o_miss_count (o_miss_count),
    .o_busy_cycles(o_busy_cycles)
  );

endmodule

`default_nettype wire

// File: dv/ifu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// protocol and cache behavior checks bound into ifu_top
module tb_ifu_assertions
  import fetch_pkg::*;
  import perf_pkg::*;
#(
  parameter int CACHE_LINES = 16
) (
  input logic      i_clock,
  input logic      i_arst_n,
  input logic      i_pc_update,
  input addr_t     i_pc_next,
  input logic      i_inst_ready,
  input logic      o_inst_valid,
  input inst_t     o_inst,
  input logic      o_inst_fault,
  input addr_t     o_pc,
  input logic      o_arvalid,
  input addr_t     o_araddr,
  input logic      i_arready,
  input logic      i_rvalid,
  input inst_t     i_rdata,
  input resp_t     i_rresp,
  input logic      o_rready,
  input perf_cnt_t o_hit_count,
  input perf_cnt_t o_miss_count,
  input perf_cnt_t o_busy_cycles
);

  localparam int IDX_W = $clog2(CACHE_LINES);

  int unsigned            fail_count = 0;
  logic [CACHE_LINES-1:0] seen_valid;
  logic [ADDR_W-3:0]      seen_word [CACHE_LINES];
  logic [IDX_W-1:0]       req_idx;
  logic [IDX_W-1:0]       fill_idx;
  logic                   fill;
  logic                   pc_cached;

  // lines the cache should hold according to the okay R beats seen so far
  assign req_idx   = i_pc_next[IDX_W+1:2];
  assign fill_idx  = o_pc[IDX_W+1:2];
  assign fill      = o_rready && i_rvalid && (i_rresp == '0);
  assign pc_cached = seen_valid[req_idx] && (seen_word[req_idx] == i_pc_next[ADDR_W-1:2]);

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      seen_valid <= '0;
    end else if (fill) begin
      seen_valid[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge i_clock) begin
    if (fill) begin
      seen_word[fill_idx] <= o_pc[ADDR_W-1:2];
    end
  end

  task automatic flag_failure(input string what);
    fail_count++;
    $error("%s", what);
  endtask

  a_reset_quiet: assert property (@(posedge i_clock) !i_arst_n |=>
      !o_arvalid && !o_rready && !o_inst_valid && (o_hit_count == '0) &&
      (o_miss_count == '0) && (o_busy_cycles == '0))
    else flag_failure("outputs or counters not cleared by reset");

  a_ar_hold: assert property (@(posedge i_clock) disable iff (!i_arst_n)
      o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr))
    else flag_failure("o_arvalid dropped or o_araddr changed before i_arready");

  a_inst_hold: assert property (@(posedge i_clock) disable iff (!i_arst_n)
      o_inst_valid && !i_inst_ready |=> o_inst_valid && $stable(o_inst) &&
      $stable(o_pc) && $stable(o_inst_fault))
    else flag_failure("o_inst_valid dropped or decode outputs changed before i_inst_ready");

  a_pc_capture: assert property (@(posedge i_clock) disable iff (!i_arst_n)
      i_pc_update |=> o_pc == $past(i_pc_next))
    else flag_failure("o_pc does not follow the requested pc");

  // a hit delivers two cycles after the pulse without touching the bus
  a_hit_latency: assert property (@(posedge i_clock) disable iff (!i_arst_n)
      $past(i_pc_update && pc_cached, 2) |-> o_inst_valid && !o_arvalid &&
      !$past(o_inst_valid) && !$past(o_arvalid))
    else flag_failure("cached pc not delivered two cycles after the update");

  a_miss_request: assert property (@(posedge i_clock) disable iff (!i_arst_n)
      $past(i_pc_update && !pc_cached, 2) |-> o_arvalid && (o_araddr == $past(i_pc_next, 2)))
    else flag_failure("uncached pc did not raise an AR request for its address");

  a_r_forward: assert property (@(posedge i_clock) disable iff (!i_arst_n)
      o_rready && i_rvalid |=> o_inst_valid && (o_inst == $past(i_rdata)) &&
      (o_inst_fault == ($past(i_rresp) != '0)))
    else flag_failure("R beat not presented to decode with its fault flag");

endmodule

`default_nettype wire

// File: dv/tb_ifu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ifu
  import fetch_pkg::*;
  import perf_pkg::*;
();

  localparam int    CACHE_LINES = 16;
  localparam int    IDX_W       = $clog2(CACHE_LINES);
  localparam int    N_FETCH     = 60;
  localparam int    MAX_CYCLES  = N_FETCH * 12 + 200;
  localparam addr_t BAD_ADDR    = 32'h0000_2008;

  logic      clock;
  logic      arst_n;
  logic      pc_update;
  addr_t     pc_next;
  logic      inst_ready;
  logic      inst_valid;
  inst_t     inst;
  logic      inst_fault;
  addr_t     pc;
  logic      arvalid;
  addr_t     araddr;
  logic      arready;
  logic      rvalid;
  inst_t     rdata;
  resp_t     rresp;
  logic      rready;
  perf_cnt_t hit_count;
  perf_cnt_t miss_count;
  perf_cnt_t busy_cycles;

  logic [15:0]            lfsr_q;
  int                     cycle_cnt = 0;
  // reference model of the cache contents and the expected counts
  logic [CACHE_LINES-1:0] model_valid;
  addr_t                  model_addr [CACHE_LINES];
  int                     exp_hits;
  int                     exp_misses;
  int                     exp_busy;
  addr_t                  pc_list [$];

  ifu_top #(
    .CACHE_LINES(CACHE_LINES)
  ) dut_i (
    .i_clock      (clock),
    .i_arst_n     (arst_n),
    .i_pc_update  (pc_update),
    .i_pc_next    (pc_next),
    .i_inst_ready (inst_ready),
    .o_inst_valid (inst_valid),
    .o_inst       (inst),
    .o_inst_fault (inst_fault),
    .o_pc         (pc),
    .o_arvalid    (arvalid),
    .o_araddr     (araddr),
    .i_arready    (arready),
    .i_rvalid     (rvalid),
    .i_rdata      (rdata),
    .i_rresp      (rresp),
    .o_rready     (rready),
    .o_hit_count  (hit_count),
    .o_miss_count (miss_count),
    .o_busy_cycles(busy_cycles)
  );

  bind ifu_top tb_ifu_assertions #(.CACHE_LINES(CACHE_LINES)) ifu_assertions_i (.*);

  initial clock = 1'b0;
  always #2 clock = ~clock;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = (val << 1) | int'(lfsr_q[0]);
    end
  endtask

  function automatic inst_t mem_word(input addr_t addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      report_failure($sformatf("timeout, run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  always @(negedge clock) begin
    if (dut_i.ifu_assertions_i.fail_count != 0) begin
      report_failure("a bound assertion failed");
    end
  end

  // one fetch acting as write-back, memory and decode at once
  task automatic do_fetch(input addr_t addr);
    logic [IDX_W-1:0] idx;
    logic             exp_hit;
    logic             ar_done;
    logic             r_done;
    logic             accepted;
    int               ar_wait;
    int               r_wait;
    int               dec_wait;
    int               busy;
    idx = addr[IDX_W+1:2];
    exp_hit = model_valid[idx] && (model_addr[idx] == addr);
    take_bits(2, ar_wait);
    take_bits(2, r_wait);
    take_bits(2, dec_wait);
    ar_done = 1'b0;
    r_done = 1'b0;
    accepted = 1'b0;
    busy = 0;
    pc_next = addr;
    pc_update = 1'b1;
    @(posedge clock);
    #0.5;
    pc_update = 1'b0;
    while (!accepted) begin
      rvalid = 1'b0;
      if (ar_done && !r_done) begin
        if (r_wait > 0) begin
          r_wait--;
        end else begin
          rvalid = 1'b1;
          rdata  = mem_word(addr);
          rresp  = (addr == BAD_ADDR) ? 2'b10 : 2'b00;
          r_done = rready;
        end
      end
      arready = 1'b0;
      if (arvalid && !ar_done) begin
        if (ar_wait > 0) begin
          ar_wait--;
        end else begin
          arready = 1'b1;
          ar_done = 1'b1;
          check_value("o_araddr", araddr, addr);
        end
      end
      inst_ready = 1'b0;
      if (inst_valid) begin
        if (dec_wait > 0) begin
          dec_wait--;
        end else begin
          inst_ready = 1'b1;
          accepted = 1'b1;
          check_value("o_pc", pc, addr);
          check_value("o_inst", inst, mem_word(addr));
          check_value("o_inst_fault", {31'b0, inst_fault}, {31'b0, addr == BAD_ADDR});
        end
      end
      @(posedge clock);
      #0.5;
      busy++;
    end
    inst_ready = 1'b0;
    arready = 1'b0;
    rvalid = 1'b0;
    check_value("o_arvalid handshake", {31'b0, ar_done}, {31'b0, !exp_hit});
    if (exp_hit) begin
      exp_hits++;
    end else begin
      exp_misses++;
      // a faulted line is never filled
      if (addr != BAD_ADDR) begin
        model_valid[idx] = 1'b1;
        model_addr[idx] = addr;
      end
    end
    exp_busy += busy;
  endtask

  initial begin
    int rnd;
    arst_n = 1'b0;
    pc_update = 1'b0;
    pc_next = '0;
    inst_ready = 1'b0;
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = '0;
    rresp = '0;
    lfsr_q = 16'd22587;
    model_valid = '0;
    exp_hits = 0;
    exp_misses = 0;
    exp_busy = 0;
    // straight-line block twice, then an index conflict, then a bus error
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < 8; i++) begin
        pc_list.push_back(32'h1000 + 4 * i);
      end
    end
    pc_list.push_back(32'h1040);
    pc_list.push_back(32'h1000);
    pc_list.push_back(32'h1040);
    pc_list.push_back(32'h1040);
    pc_list.push_back(BAD_ADDR);
    pc_list.push_back(BAD_ADDR);
    pc_list.push_back(32'h1008);
    while (pc_list.size() < N_FETCH) begin
      take_bits(5, rnd);
      pc_list.push_back(32'h1000 + 4 * rnd);
    end
    repeat (2) @(posedge clock);
    #0.5;
    arst_n = 1'b1;
    @(posedge clock);
    #0.5;
    foreach (pc_list[i]) begin
      do_fetch(pc_list[i]);
    end
    check_value("o_hit_count", hit_count, exp_hits);
    check_value("o_miss_count", miss_count, exp_misses);
    check_value("o_busy_cycles", busy_cycles, exp_busy);
    if (dut_i.ifu_assertions_i.fail_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      report_failure("a bound assertion failed");
    end
  end

endmodule

`default_nettype wire

// File: tb.f
verilog/fetch_pkg.sv
verilog/perf_pkg.sv
verilog/icache.sv
verilog/fetch_fsm.sv
verilog/fetch_perf_counters.sv
verilog/ifu_top.sv
dv/ifu_assertions.sv
dv/tb_ifu.sv

// File: Makefile
# Verilator flow for the instruction fetch unit

VERILATOR  ?= verilator
TOP        ?= tb_ifu
RTL_TOP    ?= ifu_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --timescale 1ns/1ps
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS   ?= +verilator+error+limit+100
PASS_MSG   ?= TB PASSED

RTL_SRCS := $(filter verilog/%,$(shell cat $(FILELIST)))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
